// ==== hdl/freq_meter_pkg.sv ====
/* Frequency meter shared definitions */

package freq_meter_pkg;

  // Number of observed clocks measured against the reference
  localparam int unsigned NUM_CLKS = 2;

  // Width of the per-channel cycle counter
  localparam int unsigned COUNT_W = 10;

  // Flops in every synchronizer chain
  // Used for domain resets, reference sampling and the toggle crossing
  localparam int unsigned SYNC_STAGES = 2;

  // Unsigned cycle count
  typedef logic [COUNT_W-1:0] count_t;

  // Largest count the counter can hold, 1023 for 10 bits
  localparam count_t COUNT_MAX = '1;

  // Value of a freshly reloaded counter
  // The strobe cycle itself is the first observed cycle of the new period
  localparam count_t COUNT_RELOAD = count_t'(1);

  // One measurement as carried across the clock crossing
  // count holds observed edges per reference period, capped at COUNT_MAX
  // saturated is set once the true ratio reached COUNT_MAX
  typedef struct packed {
    count_t count;
    logic   saturated;
  } freq_sample_t;

  // Cleared sample, used for reset values
  localparam freq_sample_t SAMPLE_ZERO = '{count: '0, saturated: 1'b0};

endpackage

// ==== hdl/freq_sync_cell.sv ====
/* Single-bit flop synchronizer */

`timescale 1ns/10ps

module freq_sync_cell import freq_meter_pkg::*; (
  input  logic i_obs_clk,
  input  logic obs_rst_n,
  input  logic i_d,
  output logic o_q
);

  // Shift chain, index 0 takes the asynchronous input
  logic [SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge i_obs_clk) begin
    if (!obs_rst_n) begin
      // All stages clear together
      sync_q <= '0;
    end else begin
      sync_q[0] <= i_d;
      // Older samples move one stage further each cycle
      for (int unsigned s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // Last stage is the settled level
  // With i_d tied high this forms a delayed reset release
  assign o_q = sync_q[SYNC_STAGES-1];

endmodule

// ==== hdl/freq_edge_counter.sv ====
/* Reference edge detector and cycle counter */

`timescale 1ns/10ps

module freq_edge_counter import freq_meter_pkg::*; (
  input  logic         i_obs_clk,
  input  logic         obs_rst_n,
  input  logic         i_ref_sync,
  output logic         o_sample,
  output freq_sample_t o_value
);

  // Previous synchronized reference level
  logic   ref_last_q;
  // Observed cycles since the last strobe
  count_t count_q;
  // Sticky flag, counter ran into its ceiling
  logic   sat_q;

  always_ff @(posedge i_obs_clk) begin
    if (!obs_rst_n) begin
      ref_last_q <= 1'b0;
    end else begin
      ref_last_q <= i_ref_sync;
    end
  end

  // One-cycle strobe on a low to high change of the reference
  assign o_sample = i_ref_sync & ~ref_last_q;

  always_ff @(posedge i_obs_clk) begin
    if (!obs_rst_n) begin
      count_q <= '0;
      sat_q   <= 1'b0;
    end else if (o_sample) begin
      // Current count leaves on o_value, start the next period
      count_q <= COUNT_RELOAD;
      sat_q   <= 1'b0;
    end else begin
      // Hold at the ceiling instead of wrapping
      if (count_q != COUNT_MAX) begin
        count_q <= count_q + count_t'(1);
      end
      // Set as the counter steps onto COUNT_MAX, so N = 1023 already flags
      if (count_q == COUNT_MAX - count_t'(1)) begin
        sat_q <= 1'b1;
      end
    end
  end

  // Valid in the strobe cycle only
  assign o_value.count     = count_q;
  assign o_value.saturated = sat_q;

endmodule

// ==== hdl/freq_cdc_bus.sv ====
/* Toggle-handshake sample crossing */

`timescale 1ns/10ps

module freq_cdc_bus import freq_meter_pkg::*; (
  // Source domain, one observed clock
  input  logic         i_src_clk,
  input  logic         i_src_rst_n,
  input  logic         i_src_en,
  input  freq_sample_t i_src_data,
  // Destination domain, system clock
  input  logic         i_dst_clk,
  input  logic         i_dst_rst_n,
  output freq_sample_t o_dst_data,
  output logic         o_dst_update
);

  // Source side
  freq_sample_t src_data_q;
  logic         src_tgl_q;

  // Destination side
  logic         dst_tgl_sync;
  logic         dst_tgl_q;
  logic         dst_change;
  freq_sample_t dst_data_q;
  logic         dst_update_q;

  // Payload register, only read once the toggle has settled
  always_ff @(posedge i_src_clk) begin
    if (i_src_en) begin
      src_data_q <= i_src_data;
    end
  end

  // Each accepted sample flips the toggle
  // No busy check, a new strobe simply overwrites an in-flight sample
  always_ff @(posedge i_src_clk) begin
    if (!i_src_rst_n) begin
      src_tgl_q <= 1'b0;
    end else if (i_src_en) begin
      src_tgl_q <= ~src_tgl_q;
    end
  end

  // Bring the toggle level into the destination clock
  freq_sync_cell u_tgl_sync (
    .i_obs_clk ( i_dst_clk    ),
    .obs_rst_n ( i_dst_rst_n  ),
    .i_d       ( src_tgl_q    ),
    .o_q       ( dst_tgl_sync )
  );

  // Delayed copy for change detection
  always_ff @(posedge i_dst_clk) begin
    if (!i_dst_rst_n) begin
      dst_tgl_q <= 1'b0;
    end else begin
      dst_tgl_q <= dst_tgl_sync;
    end
  end

  // Either toggle direction marks a new sample
  assign dst_change = dst_tgl_sync ^ dst_tgl_q;

  // Source register has been stable for the whole sync delay here
  always_ff @(posedge i_dst_clk) begin
    if (!i_dst_rst_n) begin
      dst_data_q <= SAMPLE_ZERO;
    end else if (dst_change) begin
      dst_data_q <= src_data_q;
    end
  end

  // Registered pulse lines up with the new data word
  always_ff @(posedge i_dst_clk) begin
    if (!i_dst_rst_n) begin
      dst_update_q <= 1'b0;
    end else begin
      dst_update_q <= dst_change;
    end
  end

  assign o_dst_data   = dst_data_q;
  assign o_dst_update = dst_update_q;

endmodule

// ==== hdl/freq_meter.sv ====
/* Multi-channel frequency meter */

`timescale 1ns/10ps

module freq_meter import freq_meter_pkg::*; (
  input  logic                        i_clk,
  input  logic                        obs_rst_n,
  input  logic                        i_clk_ref,
  input  logic         [NUM_CLKS-1:0] i_obs_clk,
  output freq_sample_t [NUM_CLKS-1:0] o_obs_freq,
  output logic         [NUM_CLKS-1:0] o_obs_update
);

  // One measurement channel per observed clock
  for (genvar i = 0; i < NUM_CLKS; i++) begin : gen_chan
    // Domain reset, released SYNC_STAGES observed cycles after obs_rst_n
    logic         obs_rst_n_i;
    // Reference level as seen in this domain
    logic         ref_sync;
    // Strobe and count leaving the counter
    logic         sample;
    freq_sample_t sample_value;

    // Local synchronous reset for the observed domain
    freq_sync_cell u_rst_sync (
      .i_obs_clk ( i_obs_clk[i] ),
      .obs_rst_n ( obs_rst_n    ),
      .i_d       ( 1'b1         ),
      .o_q       ( obs_rst_n_i  )
    );

    // Reference clock sampled as a plain level
    freq_sync_cell u_ref_sync (
      .i_obs_clk ( i_obs_clk[i] ),
      .obs_rst_n ( obs_rst_n_i  ),
      .i_d       ( i_clk_ref    ),
      .o_q       ( ref_sync     )
    );

    // Cycles per reference period
    freq_edge_counter u_counter (
      .i_obs_clk  ( i_obs_clk[i] ),
      .obs_rst_n  ( obs_rst_n_i  ),
      .i_ref_sync ( ref_sync     ),
      .o_sample   ( sample       ),
      .o_value    ( sample_value )
    );

    // Move each result into the system clock
    // Back-pressure is not needed, a reference period spans many sync delays
    freq_cdc_bus u_cdc (
      .i_src_clk    ( i_obs_clk[i]    ),
      .i_src_rst_n  ( obs_rst_n_i     ),
      .i_src_en     ( sample          ),
      .i_src_data   ( sample_value    ),
      .i_dst_clk    ( i_clk           ),
      .i_dst_rst_n  ( obs_rst_n       ),
      .o_dst_data   ( o_obs_freq[i]   ),
      .o_dst_update ( o_obs_update[i] )
    );
  end

endmodule

// ==== dv/tb_freq_meter.sv ====
/* Frequency meter testbench */

`timescale 1ns/10ps

module tb_freq_meter import freq_meter_pkg::*; ();

  // System clock and reference timing
  localparam int  CLK_HALF_NS    = 4;
  localparam int  REF_PERIOD_NS  = 1024;
  localparam real REF_HALF_NS    = 512.0;
  localparam int  RST_CYCLES     = 5;
  // Largest count a channel can report
  localparam int  COUNT_CAP      = 1023;
  localparam int  CYCLES_PER_REF = REF_PERIOD_NS / (2 * CLK_HALF_NS);
  // Updates awaited by reset, ratio, change, saturation and stop tests
  localparam int  UPDATES_AWAITED = 2 + 10 + 6 + 12 + 5;
  localparam int  CYCLE_LIMIT     = UPDATES_AWAITED * CYCLES_PER_REF * 2;

  logic                        i_clk;
  logic                        obs_rst_n;
  logic                        i_clk_ref;
  logic         [NUM_CLKS-1:0] obs_clk;
  freq_sample_t [NUM_CLKS-1:0] obs_freq;
  logic         [NUM_CLKS-1:0] obs_update;

  // Observed clock periods in ns
  // Zero until the stimulus picks one
  int  obs_period [NUM_CLKS];
  bit  obs_stop   [NUM_CLKS];
  // Updates still to be ignored after reset or a period change
  int  skip_left  [NUM_CLKS];
  int  checked    [NUM_CLKS];
  int  chan_errs  [NUM_CLKS];
  int  main_errs;
  int  seed;
  int  cycles = 0;
  int  tests_passed;
  int  tests_failed;
  // Reference edges sit a quarter ns off the observed clock grid
  real ref_delay = REF_HALF_NS + 0.25;

  freq_meter UUT (
    .i_clk        ( i_clk      ),
    .obs_rst_n    ( obs_rst_n  ),
    .i_clk_ref    ( i_clk_ref  ),
    .i_obs_clk    ( obs_clk    ),
    .o_obs_freq   ( obs_freq   ),
    .o_obs_update ( obs_update )
  );

  always #CLK_HALF_NS i_clk = ~i_clk;

  always begin
    #(ref_delay);
    ref_delay = REF_HALF_NS;
    i_clk_ref = ~i_clk_ref;
  end

  // Run limit
  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d system clock cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Expected sample for an observed period
  // N = 1024 / period capped at 1023
  function automatic freq_sample_t model_sample(input int period_ns);
    freq_sample_t s;
    int           n;
    n = REF_PERIOD_NS / period_ns;
    s.saturated = (n >= COUNT_CAP);
    s.count     = (n >= COUNT_CAP) ? count_t'(COUNT_CAP) : count_t'(n);
    return s;
  endfunction

  // Even divisors of 1024 from 2 to 64 ns
  function int pick_period();
    int idx;
    idx = $unsigned($random(seed)) % 6;
    return 2 << idx;
  endfunction

  function automatic int total_errors();
    int sum;
    sum = main_errs;
    for (int c = 0; c < NUM_CLKS; c++) begin
      sum = sum + chan_errs[c];
    end
    return sum;
  endfunction

  for (genvar c = 0; c < NUM_CLKS; c++) begin : gen_chan
    logic clk_q = 1'b0;

    // Stopped clock keeps its level
    always begin
      wait (obs_period[c] != 0);
      #(obs_period[c] / 2.0);
      if (!obs_stop[c]) begin
        clk_q = ~clk_q;
      end
    end

    assign obs_clk[c] = clk_q;

    // Update monitor
    // Outputs settle half a cycle after the rising edge
    always @(negedge i_clk) begin
      freq_sample_t exp_s;
      if (obs_update[c]) begin
        if (skip_left[c] > 0) begin
          skip_left[c] = skip_left[c] - 1;
        end else begin
          exp_s = model_sample(obs_period[c]);
          assert (obs_freq[c] == exp_s) else begin
            $display("Mismatch at %0t: channel %0d expected count %0d sat %0b, got %0d sat %0b",
                     $realtime, c, exp_s.count, exp_s.saturated,
                     obs_freq[c].count, obs_freq[c].saturated);
            chan_errs[c] = chan_errs[c] + 1;
          end
          checked[c] = checked[c] + 1;
        end
      end
    end
  end

  // Outputs before the first measurement
  task automatic check_idle();
    assert (obs_update == '0) else begin
      $display("Update pulse at %0t before any measurement was ready", $realtime);
      main_errs++;
    end
    for (int c = 0; c < NUM_CLKS; c++) begin
      assert (obs_freq[c] == '0) else begin
        $display("Mismatch at %0t: channel %0d expected count 0 sat 0, got %0d sat %0b",
                 $realtime, c, obs_freq[c].count, obs_freq[c].saturated);
        main_errs++;
      end
    end
  endtask

  // New period lands in a cycle without an update on that channel
  task automatic set_period(input int c, input int period_ns);
    @(negedge i_clk);
    while (obs_update[c]) begin
      @(negedge i_clk);
    end
    obs_period[c] = period_ns;
    skip_left[c]  = 2;
    $display("Channel %0d period set to %0d ns", c, period_ns);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (total_errors() == errs_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, total_errors() - errs_before);
    end
  endtask

  initial begin
    int           begin_errs;
    int           base;
    int           new_p;
    int           seen1;
    freq_sample_t held;
    $timeformat(-9, 2, " ns", 10);
    seed         = 6;
    i_clk        = 1'b0;
    obs_rst_n    = 1'b0;
    i_clk_ref    = 1'b0;
    main_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int c = 0; c < NUM_CLKS; c++) begin
      obs_stop[c]   = 1'b0;
      skip_left[c]  = 2;
      checked[c]    = 0;
      chan_errs[c]  = 0;
      obs_period[c] = pick_period();
      $display("Channel %0d period set to %0d ns", c, obs_period[c]);
    end

    // Reset state
    begin_errs = total_errors();
    repeat (RST_CYCLES) begin
      @(negedge i_clk);
      check_idle();
    end
    obs_rst_n = 1'b1;
    @(negedge i_clk);
    while (obs_update == '0) begin
      check_idle();
      @(negedge i_clk);
    end
    finish_test("reset state", begin_errs);

    // Integer ratios on both channels
    begin_errs = total_errors();
    wait (checked[0] >= 8 && checked[1] >= 8);
    finish_test("integer ratios", begin_errs);

    // Ratio change on channel 0
    // Channel 1 keeps being checked meanwhile
    begin_errs = total_errors();
    do begin
      new_p = pick_period();
    end while (new_p == obs_period[0]);
    set_period(0, new_p);
    base = checked[0];
    wait (checked[0] >= base + 4);
    finish_test("ratio change", begin_errs);

    // Period of 1 ns gives N = 1024 on channel 1
    begin_errs = total_errors();
    set_period(1, 1);
    base = checked[1];
    wait (checked[1] >= base + 4);
    set_period(1, pick_period());
    base = checked[1];
    wait (checked[1] >= base + 4);
    finish_test("saturation", begin_errs);

    // Stop channel 0
    // An in-flight sample may still land first
    begin_errs = total_errors();
    @(negedge i_clk);
    obs_stop[0] = 1'b1;
    repeat (16) @(negedge i_clk);
    // Last full measurement before the stop
    held  = model_sample(obs_period[0]);
    seen1 = 0;
    repeat (4 * CYCLES_PER_REF) begin
      @(negedge i_clk);
      assert (!obs_update[0]) else begin
        $display("Channel 0 gave an update pulse at %0t while its clock was stopped",
                 $realtime);
        main_errs++;
      end
      assert (obs_freq[0] == held) else begin
        $display("Mismatch at %0t: channel 0 expected held count %0d sat %0b, got %0d sat %0b",
                 $realtime, held.count, held.saturated,
                 obs_freq[0].count, obs_freq[0].saturated);
        main_errs++;
      end
      if (obs_update[1]) begin
        seen1++;
      end
    end
    assert (seen1 >= 3) else begin
      $display("Channel 1 stopped updating while channel 0 was stopped");
      main_errs++;
    end
    finish_test("stopped clock", begin_errs);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/freq_meter_pkg.sv
hdl/freq_sync_cell.sv
hdl/freq_edge_counter.sv
hdl/freq_cdc_bus.sv
hdl/freq_meter.sv
dv/tb_freq_meter.sv

// ==== Bender.yml ====
package:
  name: freq_meter

sources:
  - files:
      - hdl/freq_meter_pkg.sv
      - hdl/freq_sync_cell.sv
      - hdl/freq_edge_counter.sv
      - hdl/freq_cdc_bus.sv
      - hdl/freq_meter.sv
  - target: test
    files:
      - dv/tb_freq_meter.sv
